// ==== src/iob_cache_pkg.sv ====
package iob_cache_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////
   localparam int FE_ADDR_W  = 16;             // byte address
   localparam int FE_DATA_W  = 32;
   localparam int FE_BYTE_W  = $clog2(FE_DATA_W/8); // byte offset bits
   localparam int LINE_OFF_W = 3;              // 8 lines
   localparam int WORD_OFF_W = 2;              // 4 words per line

   typedef logic [FE_ADDR_W-FE_BYTE_W-1:0] fe_addr_t;    // word address
   typedef logic [FE_DATA_W-1:0]           word_t;
   typedef logic [FE_DATA_W/8-1:0]         wstrb_t;
   typedef logic [LINE_OFF_W-1:0]          line_idx_t;
   typedef logic [WORD_OFF_W-1:0]          word_off_t;
   typedef logic [FE_ADDR_W-FE_BYTE_W-LINE_OFF_W-WORD_OFF_W-1:0] tag_t;

   // sequencer states
   typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_WAIT_DRAIN, S_REFILL, S_RESPOND} seq_state_t;

endpackage

// ==== src/cache_ifs.sv ====
`timescale 1ns/1ps

// write channel, sequencer -> buffer and buffer -> back end
interface wr_chan_if import iob_cache_pkg::*; ();
   logic     valid;   // held until ready
   fe_addr_t addr;
   word_t    wdata;
   wstrb_t   wstrb;
   logic     ready;

   modport src (output valid, addr, wdata, wstrb, input ready);
   modport dst (input valid, addr, wdata, wstrb, output ready);
endinterface

// line replacement channel, sequencer <-> back end
interface refill_if import iob_cache_pkg::*; ();
   logic                                       replace_valid;
   logic [$bits(tag_t)+$bits(line_idx_t)-1:0]  replace_addr;  // tag and index
   logic                                       replace_ready; // one cycle after last word
   logic                                       read_valid;    // one pulse per word
   word_off_t                                  read_addr;
   word_t                                      read_rdata;

   modport req (output replace_valid, replace_addr,
                input replace_ready, read_valid, read_addr, read_rdata);
   modport rsp (input replace_valid, replace_addr,
                output replace_ready, read_valid, read_addr, read_rdata);
endinterface

// ==== src/front_end.sv ====
`timescale 1ns/1ps

module front_end import iob_cache_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   // master side
   input  logic                 valid,
   input  logic [FE_ADDR_W-1:0] addr,
   input  word_t                wdata,
   input  wstrb_t               wstrb,
   // from sequencer
   input  logic                 accept,
   input  logic                 resp_valid,
   input  word_t                resp_data,
   // registered request
   output fe_addr_t             req_addr,
   output word_t                req_wdata,
   output wstrb_t               req_wstrb,
   // back to master
   output word_t                rdata,
   output logic                 ready
);

   logic take;   // request accepted this edge

   assign take = valid && accept && rst_n;

   // request register, payload only
   always_ff @(posedge clk)
   begin
      if (take)
      begin
         req_addr  <= addr[FE_ADDR_W-1:FE_BYTE_W];  // drop byte offset
         req_wdata <= wdata;
         req_wstrb <= wstrb;
      end
   end

   // response passes straight through
   assign ready = resp_valid;
   assign rdata = resp_data;

endmodule

// ==== src/cache_sequencer.sv ====
`timescale 1ns/1ps

module cache_sequencer import iob_cache_pkg::*;
#(
   parameter int WORD_OFF_W = iob_cache_pkg::WORD_OFF_W
)
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      valid,
   output logic      accept,
   // registered request
   input  fe_addr_t  req_addr,
   input  word_t     req_wdata,
   input  wstrb_t    req_wstrb,
   // cache store
   input  logic      hit,
   input  word_t     hit_data,
   output logic      store_we,
   output logic      refill_we,
   output word_off_t refill_off,
   output word_t     refill_data,
   // write path
   input  logic      wtbuf_empty,
   wr_chan_if.src    wr,
   // line refill
   refill_if.req     rf,
   // response
   output logic      resp_valid,
   output word_t     resp_data
);

   seq_state_t              state, next_state;
   logic                    is_write;   // any strobe set
   logic [WORD_OFF_W-1:0]   req_off;
   word_t                   fill_word;  // requested word seen during refill

   assign is_write = |req_wstrb;
   assign req_off  = req_addr[WORD_OFF_W-1:0];

   //////////////////////////////
   // state register
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= S_IDLE;
      else
         state <= next_state;
   end

   always_comb
   begin
      next_state       = state;
      accept           = 1'b0;
      resp_valid       = 1'b0;
      store_we         = 1'b0;
      wr.valid         = 1'b0;
      rf.replace_valid = 1'b0;
      unique case (state)
         S_IDLE:
         begin
            accept = 1'b1;
            if (valid)
               next_state = S_LOOKUP;
         end
         S_LOOKUP:
         begin
            if (is_write)
            begin
               wr.valid = 1'b1;   // write-through, hit or miss
               if (wr.ready)
               begin
                  store_we   = hit;  // no allocate on miss
                  resp_valid = 1'b1;
                  next_state = S_IDLE;
               end
            end
            else if (hit)
            begin
               resp_valid = 1'b1;
               next_state = S_IDLE;
            end
            else
               next_state = S_WAIT_DRAIN;
         end
         S_WAIT_DRAIN:
         begin
            if (wtbuf_empty)   // older writes reach memory first
               next_state = S_REFILL;
         end
         S_REFILL:
         begin
            rf.replace_valid = 1'b1;
            if (rf.replace_ready)
               next_state = S_RESPOND;
         end
         S_RESPOND:
         begin
            resp_valid = 1'b1;
            next_state = S_IDLE;
         end
         default: next_state = S_IDLE;
      endcase
   end

   // write channel fields straight from request reg
   assign wr.addr  = req_addr;
   assign wr.wdata = req_wdata;
   assign wr.wstrb = req_wstrb;

   assign rf.replace_addr = req_addr[$bits(fe_addr_t)-1:WORD_OFF_W];  // line address

   //////////////////////////////
   // refill words into the store
   //////////////////////////////
   assign refill_we   = (state == S_REFILL) && rf.read_valid;
   assign refill_off  = rf.read_addr;
   assign refill_data = rf.read_rdata;

   always_ff @(posedge clk)
   begin
      if (refill_we && (refill_off == req_off))
         fill_word <= refill_data;   // catch requested word on the fly
   end

   assign resp_data = (state == S_RESPOND) ? fill_word : hit_data;

endmodule

// ==== src/cache_store.sv ====
`timescale 1ns/1ps

module cache_store import iob_cache_pkg::*;
#(
   parameter int LINE_OFF_W = iob_cache_pkg::LINE_OFF_W,
   parameter int WORD_OFF_W = iob_cache_pkg::WORD_OFF_W
)
(
   input  logic      clk,
   input  logic      rst_n,
   input  fe_addr_t  req_addr,
   input  word_t     wdata,
   input  wstrb_t    wstrb,
   input  logic      store_we,     // write hit
   input  logic      refill_we,
   input  word_off_t refill_off,
   input  word_t     refill_data,
   output logic      hit,
   output word_t     hit_data
);

   localparam int TAG_W   = $bits(fe_addr_t) - LINE_OFF_W - WORD_OFF_W;
   localparam int N_LINES = 2**LINE_OFF_W;
   localparam int N_WORDS = 2**(LINE_OFF_W+WORD_OFF_W);

   logic [N_LINES-1:0]    valid_bits;
   logic [TAG_W-1:0]      tag_mem  [N_LINES];
   word_t                 data_mem [N_WORDS];   // {index, offset}
   logic [TAG_W-1:0]      tag;
   logic [LINE_OFF_W-1:0] idx;
   logic [WORD_OFF_W-1:0] off;

   // address fields
   assign tag = req_addr[$bits(fe_addr_t)-1 -: TAG_W];
   assign idx = req_addr[WORD_OFF_W +: LINE_OFF_W];
   assign off = req_addr[WORD_OFF_W-1:0];

   // lookup
   assign hit      = valid_bits[idx] && (tag_mem[idx] == tag);
   assign hit_data = data_mem[{idx, off}];

   // valid bits, cleared on first refill word, set on last
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         valid_bits <= '0;
      else if (refill_we && (refill_off == '0))
         valid_bits[idx] <= 1'b0;
      else if (refill_we && (&refill_off))
         valid_bits[idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (refill_we && (refill_off == '0))
         tag_mem[idx] <= tag;   // new owner of the line
   end

   // data array, refill word or byte-strobed hit
   always_ff @(posedge clk)
   begin
      if (refill_we)
         data_mem[{idx, refill_off}] <= refill_data;
      else if (store_we)
      begin
         for (int b = 0; b < FE_DATA_W/8; b++)
         begin
            if (wstrb[b])
               data_mem[{idx, off}][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

endmodule

// ==== src/write_through_buffer.sv ====
`timescale 1ns/1ps

module write_through_buffer import iob_cache_pkg::*;
#(
   parameter int WTBUF_DEPTH_W = 2
)
(
   input  logic   clk,
   input  logic   rst_n,
   wr_chan_if.dst in_ch,
   wr_chan_if.src out_ch,
   output logic   empty
);

   localparam int DEPTH = 2**WTBUF_DEPTH_W;

   fe_addr_t                 addr_mem [DEPTH];
   word_t                    data_mem [DEPTH];
   wstrb_t                   strb_mem [DEPTH];
   logic [WTBUF_DEPTH_W-1:0] wptr, rptr;
   logic [WTBUF_DEPTH_W:0]   count;         // one extra bit for full
   logic                     full, push, pop;

   assign full  = count == (WTBUF_DEPTH_W+1)'(DEPTH);
   assign empty = count == '0;

   assign in_ch.ready  = !full || out_ch.ready;   // full still takes one if popping
   assign out_ch.valid = !empty;
   assign push = in_ch.valid && in_ch.ready;
   assign pop  = out_ch.valid && out_ch.ready;

   // head entry
   assign out_ch.addr  = addr_mem[rptr];
   assign out_ch.wdata = data_mem[rptr];
   assign out_ch.wstrb = strb_mem[rptr];

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         addr_mem[wptr] <= in_ch.addr;
         data_mem[wptr] <= in_ch.wdata;
         strb_mem[wptr] <= in_ch.wstrb;
      end
   end

   // pointers and fill level
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end
      else
      begin
         if (push)
            wptr <= wptr + 1'b1;   // wraps
         if (pop)
            rptr <= rptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

endmodule

// ==== src/back_end_native.sv ====
`timescale 1ns/1ps

module back_end_native import iob_cache_pkg::*;
#(
   parameter int WORD_OFF_W = iob_cache_pkg::WORD_OFF_W
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   wr_chan_if.dst               wr,
   refill_if.rsp                rf,
   // native memory port
   output logic                 mem_valid,
   output logic [FE_ADDR_W-1:0] mem_addr,
   output word_t                mem_wdata,
   output wstrb_t               mem_wstrb,
   input  word_t                mem_rdata,
   input  logic                 mem_ready
);

   typedef enum logic [1:0] {BE_IDLE, BE_REFILL, BE_WRITE} be_state_t;

   be_state_t             state;
   logic [WORD_OFF_W-1:0] cnt;   // refill word counter

   //////////////////////////////
   // transaction sequencing
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state            <= BE_IDLE;
         cnt              <= '0;
         rf.replace_ready <= 1'b0;
      end
      else
      begin
         rf.replace_ready <= 1'b0;   // single pulse
         unique case (state)
            BE_IDLE:
            begin
               // refill wins, but not again in its own ready cycle
               if (rf.replace_valid && !rf.replace_ready)
               begin
                  state <= BE_REFILL;
                  cnt   <= '0;
               end
               else if (wr.valid)
                  state <= BE_WRITE;
            end
            BE_REFILL:
            begin
               if (mem_ready)
               begin
                  cnt <= cnt + 1'b1;
                  if (&cnt)   // last word of line
                  begin
                     state            <= BE_IDLE;
                     rf.replace_ready <= 1'b1;
                  end
               end
            end
            BE_WRITE:
            begin
               if (mem_ready)
                  state <= BE_IDLE;
            end
            default: state <= BE_IDLE;
         endcase
      end
   end

   // memory request, word address -> byte address
   always_comb
   begin
      mem_valid     = state != BE_IDLE;
      mem_addr      = {wr.addr, {FE_BYTE_W{1'b0}}};
      mem_wdata     = wr.wdata;
      mem_wstrb     = wr.wstrb;
      wr.ready      = 1'b0;
      rf.read_valid = 1'b0;
      if (state == BE_REFILL)
      begin
         mem_addr      = {rf.replace_addr, cnt, {FE_BYTE_W{1'b0}}};
         mem_wdata     = '0;
         mem_wstrb     = '0;          // read
         rf.read_valid = mem_ready;
      end
      else if (state == BE_WRITE)
         wr.ready = mem_ready;        // pop only when memory took it
   end

   assign rf.read_addr  = cnt;
   assign rf.read_rdata = mem_rdata;

endmodule

// ==== src/iob_cache.sv ====
`timescale 1ns/1ps

module iob_cache import iob_cache_pkg::*;
#(
   parameter int LINE_OFF_W    = iob_cache_pkg::LINE_OFF_W,
   parameter int WORD_OFF_W    = iob_cache_pkg::WORD_OFF_W,
   parameter int WTBUF_DEPTH_W = 2
)
(
   input  logic                 clk,
   input  logic                 rst_n,
   // master port
   input  logic                 valid,
   input  logic [FE_ADDR_W-1:0] addr,
   input  word_t                wdata,
   input  wstrb_t               wstrb,
   output word_t                rdata,
   output logic                 ready,
   // memory port
   output logic                 mem_valid,
   output logic [FE_ADDR_W-1:0] mem_addr,
   output word_t                mem_wdata,
   output wstrb_t               mem_wstrb,
   input  word_t                mem_rdata,
   input  logic                 mem_ready
);

   fe_addr_t  req_addr;
   word_t     req_wdata, resp_data, hit_data, refill_data;
   wstrb_t    req_wstrb;
   logic      accept, resp_valid, hit, store_we, refill_we, wtbuf_empty;
   word_off_t refill_off;

   wr_chan_if seq_wr ();   // sequencer -> buffer
   wr_chan_if buf_wr ();   // buffer -> back end
   refill_if  rf ();

   //////////////////////////////
   // front end and control
   //////////////////////////////
   front_end u_front_end (.clk, .rst_n, .valid, .addr, .wdata, .wstrb, .accept,
      .resp_valid, .resp_data, .req_addr, .req_wdata, .req_wstrb, .rdata, .ready);

   cache_sequencer #(.WORD_OFF_W(WORD_OFF_W)) u_cache_sequencer (.clk, .rst_n, .valid,
      .accept, .req_addr, .req_wdata, .req_wstrb, .hit, .hit_data, .store_we, .refill_we,
      .refill_off, .refill_data, .wtbuf_empty, .wr(seq_wr.src), .rf(rf.req), .resp_valid,
      .resp_data);

   // tag and data store
   cache_store #(.LINE_OFF_W(LINE_OFF_W), .WORD_OFF_W(WORD_OFF_W)) u_cache_store (.clk,
      .rst_n, .req_addr, .wdata(req_wdata), .wstrb(req_wstrb), .store_we, .refill_we,
      .refill_off, .refill_data, .hit, .hit_data);

   //////////////////////////////
   // memory side
   //////////////////////////////
   write_through_buffer #(.WTBUF_DEPTH_W(WTBUF_DEPTH_W)) u_wtbuf (.clk, .rst_n,
      .in_ch(seq_wr.dst), .out_ch(buf_wr.src), .empty(wtbuf_empty));

   back_end_native #(.WORD_OFF_W(WORD_OFF_W)) u_back_end (.clk, .rst_n, .wr(buf_wr.dst),
      .rf(rf.rsp), .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata, .mem_ready);

endmodule

// ==== test/iob_cache_tb.sv ====
`timescale 1ns/1ps

module iob_cache_tb import iob_cache_pkg::*; ();

   typedef struct packed {
      logic [15:0] addr;           // byte address
      word_t       wdata;
      wstrb_t      wstrb;          // zero means read
      word_t       exp_rdata;
      logic        expect_refill;
      logic        slow;           // memory at its longest delay
   } row_t;

   localparam int N_ROWS         = 18;
   localparam int TIMEOUT_CYCLES = N_ROWS * 40;

   logic clk;
   logic rst_n = 1'b0;
   logic valid;
   logic [FE_ADDR_W-1:0] addr;
   word_t wdata, rdata, mem_wdata;
   word_t mem_rdata = '0;
   wstrb_t wstrb, mem_wstrb;
   logic ready, mem_valid;
   logic mem_ready = 1'b0;
   logic [FE_ADDR_W-1:0] mem_addr;

   row_t        rows [N_ROWS];
   word_t       mem [1024];
   logic [31:0] lfsr = 32'h5ae17cc7;
   logic        slow_mem = 1'b0;
   logic        pending;
   logic [1:0]  delay;
   int          mem_reads = 0;   // refill reads seen by the memory model
   int          errors = 0;
   int          stalls = 0;
   int          cycles = 0;
   logic [15:0] exp_wr_addr [$];  // writes expected at memory, in order
   word_t       exp_wr_data [$];
   wstrb_t      exp_wr_strb [$];

   iob_cache iob_cache_i (.clk, .rst_n, .valid, .addr, .wdata, .wstrb, .rdata, .ready,
      .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata, .mem_ready);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // taps 32 22 2 1
   function automatic logic rand_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic drive_row(int i);
      valid    <= 1'b1;
      addr     <= rows[i].addr;
      wdata    <= rows[i].wdata;
      wstrb    <= rows[i].wstrb;
      slow_mem <= rows[i].slow;
      if (rows[i].wstrb != '0)   // every write must show up at memory
      begin
         exp_wr_addr.push_back(rows[i].addr);
         exp_wr_data.push_back(rows[i].wdata);
         exp_wr_strb.push_back(rows[i].wstrb);
      end
   endtask

   //////////////////////////////
   // memory model
   //////////////////////////////
   initial
      for (int i = 0; i < 1024; i++)
         mem[i] = {16'hc0de, 16'(i)};   // pattern from word address

   always @(posedge clk)
   begin : mem_model
      logic [9:0] w;
      logic [1:0] d;
      w = mem_addr[11:2];
      if (!rst_n)
      begin
         mem_ready <= 1'b0;
         pending   <= 1'b0;
      end
      else
      begin
         mem_ready <= 1'b0;   // one cycle pulse
         if (mem_valid && !mem_ready)
         begin
            if (!pending)
            begin
               if (slow_mem)
                  d = 2'd3;
               else
               begin
                  d[1] = rand_bit();
                  d[0] = rand_bit();
               end
               pending <= 1'b1;
               delay   <= d;
            end
            else if (delay != 2'd0)
               delay <= delay - 2'd1;
            else
            begin
               pending   <= 1'b0;
               mem_ready <= 1'b1;
               mem_rdata <= mem[w];
               if (mem_wstrb == '0)
                  mem_reads++;
               else if (exp_wr_addr.size() == 0)
               begin
                  $display("memory write at %0t ns with no write outstanding", $time);
                  errors++;
               end
               else
               begin
                  check_value("mem_addr", mem_addr, exp_wr_addr.pop_front());
                  check_value("mem_wdata", mem_wdata, exp_wr_data.pop_front());
                  check_value("mem_wstrb", mem_wstrb, exp_wr_strb.pop_front());
                  for (int b = 0; b < 4; b++)
                     if (mem_wstrb[b])
                        mem[w][8*b +: 8] = mem_wdata[8*b +: 8];
               end
            end
         end
      end
   end

   // watchdog
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // stimulus and checks
   //////////////////////////////
   initial
   begin
      int   lat;
      int   reads_mark;
      logic saw_refill;
      rows = '{
         '{16'h0040, 32'h0, 4'h0, 32'hc0de_0010, 1'b1, 1'b0},  // read miss, line 4
         '{16'h0044, 32'h0, 4'h0, 32'hc0de_0011, 1'b0, 1'b0},  // hits on same line
         '{16'h0048, 32'h0, 4'h0, 32'hc0de_0012, 1'b0, 1'b0},
         '{16'h004c, 32'h0, 4'h0, 32'hc0de_0013, 1'b0, 1'b0},
         '{16'h0048, 32'haabbccdd, 4'b0101, 32'h0, 1'b0, 1'b0},  // write hit, bytes 0 and 2
         '{16'h0048, 32'h0, 4'h0, 32'hc0bb_00dd, 1'b0, 1'b0},  // merged word
         '{16'h0200, 32'h12345678, 4'hf, 32'h0, 1'b0, 1'b0},   // write miss, no allocate
         '{16'h0200, 32'h0, 4'h0, 32'h1234_5678, 1'b1, 1'b0},  // refill after drain
         '{16'h0300, 32'h11110000, 4'hf, 32'h0, 1'b0, 1'b1},   // burst into slow memory
         '{16'h0304, 32'h11110001, 4'hf, 32'h0, 1'b0, 1'b1},
         '{16'h0308, 32'h11110002, 4'hf, 32'h0, 1'b0, 1'b1},
         '{16'h030c, 32'h11110003, 4'hf, 32'h0, 1'b0, 1'b1},
         '{16'h0310, 32'h11110004, 4'hf, 32'h0, 1'b0, 1'b1},
         '{16'h0314, 32'h11110005, 4'hf, 32'h0, 1'b0, 1'b1},
         '{16'h0304, 32'h0, 4'h0, 32'h1111_0001, 1'b1, 1'b0},  // burst data landed
         '{16'h00c0, 32'h0, 4'h0, 32'hc0de_0030, 1'b1, 1'b0},  // index 4, tag 1
         '{16'h0040, 32'h0, 4'h0, 32'hc0de_0010, 1'b1, 1'b0},  // index 4, tag 0 again
         '{16'h00c4, 32'h0, 4'h0, 32'hc0de_0031, 1'b1, 1'b0}
      };
      valid <= 1'b0;
      addr  <= '0;
      wdata <= '0;
      wstrb <= '0;
      reads_mark = 0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      drive_row(0);
      for (int i = 0; i < N_ROWS; i++)
      begin
         lat = 0;
         do
         begin
            @(negedge clk);
            lat++;
         end while (!ready);
         saw_refill = mem_reads != reads_mark;
         reads_mark = mem_reads;
         check_value("refill", saw_refill, rows[i].expect_refill);
         if (rows[i].wstrb == '0)
         begin
            check_value("rdata", rdata, rows[i].exp_rdata);
            if (!rows[i].expect_refill)   // accept edge, then ready next cycle
               check_value("ready latency", lat, 2);
         end
         else if (rows[i].slow && lat > 2)
            stalls++;
         @(posedge clk);
         if (i + 1 < N_ROWS)
            drive_row(i + 1);   // back to back
         else
            valid <= 1'b0;
      end
      while (exp_wr_addr.size() != 0)
         @(negedge clk);
      check_value("mem[0x0048]", mem[10'h012], 32'hc0bb_00dd);
      if (stalls == 0)
      begin
         $display("the full write buffer never held back the master");
         errors++;
      end
      $display("%0d errors over %0d requests", errors, N_ROWS);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== project.f ====
src/iob_cache_pkg.sv
src/cache_ifs.sv
src/front_end.sv
src/cache_sequencer.sv
src/cache_store.sv
src/write_through_buffer.sv
src/back_end_native.sv
src/iob_cache.sv
test/iob_cache_tb.sv

// ==== Makefile ====
# Verilator flow for the cache and its testbench

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= iob_cache_tb
RTL_TOP   ?= iob_cache
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
